/* spw_rx_top.f */
spw_rx_pkg.sv
spw_rx_bit_recovery.sv
spw_rx_char_shift.sv
spw_rx_char_decode.sv
spw_rx_classify.sv
spw_rx_top.sv
spw_rx_checker.sv
spw_rx_tb.sv

/* Makefile */
# Verilator build and run of the SpaceWire receiver testbench

SRCS := $(wildcard *.sv)

obj_dir/Vspw_rx_tb: $(SRCS) spw_rx_top.f
	verilator --binary --assert -j 0 --top-module spw_rx_tb -f spw_rx_top.f

run: obj_dir/Vspw_rx_tb
	./obj_dir/Vspw_rx_tb | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* spw_rx_tb.sv */
/*
 * SpaceWire receiver testbench
 * Sends a seeded random stream of data, EOP, EEP, FCT, NULL and time
 * code characters over the data and strobe lines, with random bit hold
 * times and some injected faults, and feeds expected tokens to the checker.
 */

`timescale 1ns/100ps
`default_nettype none

module spw_rx_tb;

	localparam int token_total  = 300;
	localparam int drain_cycles = 2000;
	localparam int quiet_cycles = 40;

	// Token kinds, as the checker codes them
	localparam int kind_data    = 0;
	localparam int kind_eop     = 1;
	localparam int kind_eep     = 2;
	localparam int kind_fct     = 3;
	localparam int kind_null    = 4;
	localparam int kind_time    = 5;
	localparam int kind_par_err = 6;
	localparam int kind_esc_err = 7;

	// Control codes from the standard
	localparam logic [1:0] code_fct = 2'd0;
	localparam logic [1:0] code_eop = 2'd1;
	localparam logic [1:0] code_eep = 2'd2;
	localparam logic [1:0] code_esc = 2'd3;

	logic posedge_clk;
	logic rx_resetn;
	logic din;
	logic sin;
	logic [7:0] rx_data;
	logic rx_data_valid;
	logic rx_eop;
	logic rx_eep;
	logic rx_fct;
	logic rx_null;
	logic [5:0] rx_time;
	logic [1:0] rx_time_flags;
	logic rx_time_valid;
	logic parity_error;
	logic escape_error;

	// Line levels as last driven
	logic d_line;
	logic s_line;
	// XOR of the previous payload
	logic prev_xor;
	// Model state
	logic first_char;
	logic esc_pending;
	logic timed_out;

	always #2 posedge_clk = ~posedge_clk;

	spw_rx_top spw_rx_top_inst (
		.posedge_clk   (posedge_clk),
		.rx_resetn     (rx_resetn),
		.din           (din),
		.sin           (sin),
		.rx_data       (rx_data),
		.rx_data_valid (rx_data_valid),
		.rx_eop        (rx_eop),
		.rx_eep        (rx_eep),
		.rx_fct        (rx_fct),
		.rx_null       (rx_null),
		.rx_time       (rx_time),
		.rx_time_flags (rx_time_flags),
		.rx_time_valid (rx_time_valid),
		.parity_error  (parity_error),
		.escape_error  (escape_error)
	);

	spw_rx_checker spw_rx_checker_inst (
		.posedge_clk   (posedge_clk),
		.rx_resetn     (rx_resetn),
		.rx_data       (rx_data),
		.rx_data_valid (rx_data_valid),
		.rx_eop        (rx_eop),
		.rx_eep        (rx_eep),
		.rx_fct        (rx_fct),
		.rx_null       (rx_null),
		.rx_time       (rx_time),
		.rx_time_flags (rx_time_flags),
		.rx_time_valid (rx_time_valid),
		.parity_error  (parity_error),
		.escape_error  (escape_error)
	);

	// ------------------------------------------------------------------------
	// Line encoding
	// ------------------------------------------------------------------------

	// One bit held 3 to 8 cycles
	task automatic drive_bit(input logic b);
		int hold;
		hold = 3 + int'($urandom % 6);
		@(posedge posedge_clk);
		// Strobe toggles when data repeats
		if (b == d_line)
			s_line = ~s_line;
		d_line = b;
		din <= d_line;
		sin <= s_line;
		repeat (hold - 1) @(posedge posedge_clk);
	endtask

	// About one char in twelve gets a wrong parity bit
	function automatic logic random_fault();
		return ($urandom % 12) == 0;
	endfunction

	// ------------------------------------------------------------------------
	// Expected tokens
	// ------------------------------------------------------------------------

	task automatic model_char(input logic is_ctrl, input logic [7:0] payload,
		input logic bad_par);
		logic [1:0] code;
		code = payload[1:0];
		// First char after reset has nothing to check against
		if (bad_par && !first_char)
		begin
			spw_rx_checker_inst.push_expected(kind_par_err, 8'h00);
			esc_pending = 1'b0;
		end
		else if (!is_ctrl)
		begin
			spw_rx_checker_inst.push_expected(esc_pending ? kind_time : kind_data, payload);
			esc_pending = 1'b0;
		end
		else if (esc_pending)
		begin
			spw_rx_checker_inst.push_expected(code == code_fct ? kind_null : kind_esc_err,
				8'h00);
			esc_pending = 1'b0;
		end
		else if (code == code_esc)
			esc_pending = 1'b1;
		else if (code == code_fct)
			spw_rx_checker_inst.push_expected(kind_fct, 8'h00);
		else if (code == code_eop)
			spw_rx_checker_inst.push_expected(kind_eop, 8'h00);
		else
			spw_rx_checker_inst.push_expected(kind_eep, 8'h00);
		first_char = 1'b0;
	endtask

	task automatic send_char(input logic is_ctrl, input logic [7:0] payload,
		input logic bad_par);
		logic par;
		int n;
		model_char(is_ctrl, payload, bad_par);
		// Odd parity over previous payload, parity and flag
		par = ~(is_ctrl ^ prev_xor) ^ bad_par;
		drive_bit(par);
		drive_bit(is_ctrl);
		n = is_ctrl ? 2 : 8;
		// LSB first
		for (int i = 0; i < n; i++)
			drive_bit(payload[i]);
		prev_xor = is_ctrl ? ^payload[1:0] : ^payload;
	endtask

	task automatic send_token(input int pick);
		logic [7:0] b;
		logic [1:0] follow;
		b = 8'($urandom);
		// EOP, EEP or ESC after an ESC
		follow = 2'($urandom % 3) + 2'd1;
		if (pick < 6)
			send_char(1'b0, b, random_fault());
		else if (pick == 6)
			send_char(1'b1, {6'd0, code_eop}, random_fault());
		else if (pick == 7)
			send_char(1'b1, {6'd0, code_eep}, random_fault());
		else if (pick < 10)
			send_char(1'b1, {6'd0, code_fct}, random_fault());
		else if (pick < 12)
		begin
			// NULL
			send_char(1'b1, {6'd0, code_esc}, random_fault());
			send_char(1'b1, {6'd0, code_fct}, random_fault());
		end
		else if (pick < 14)
		begin
			// Time code
			send_char(1'b1, {6'd0, code_esc}, random_fault());
			send_char(1'b0, b, random_fault());
		end
		else
		begin
			send_char(1'b1, {6'd0, code_esc}, random_fault());
			send_char(1'b1, {6'd0, follow}, random_fault());
		end
	endtask

	// ------------------------------------------------------------------------
	// Main sequence
	// ------------------------------------------------------------------------

	initial
	begin
		int wait_cycles;
		int errors;
		posedge_clk = 1'b0;
		rx_resetn = 1'b0;
		din = 1'b0;
		sin = 1'b0;
		d_line = 1'b0;
		s_line = 1'b0;
		prev_xor = 1'b0;
		first_char = 1'b1;
		esc_pending = 1'b0;
		timed_out = 1'b0;
		void'($urandom(32'he6dc));
		repeat (10) @(posedge posedge_clk);
		rx_resetn <= 1'b1;
		// Idle lines after reset, checker flags any strobe
		repeat (8) @(posedge posedge_clk);
		// First char with bad parity must still decode
		send_char(1'b0, 8'($urandom), 1'b1);
		for (int t = 1; t < token_total; t++)
			send_token(int'($urandom % 16));
		wait_cycles = 0;
		while (spw_rx_checker_inst.pending_count() > 0 && wait_cycles < drain_cycles)
		begin
			@(posedge posedge_clk);
			wait_cycles++;
		end
		if (spw_rx_checker_inst.pending_count() > 0)
		begin
			timed_out = 1'b1;
			$display("Timeout: %0d expected tokens still pending after %0d cycles",
				spw_rx_checker_inst.pending_count(), drain_cycles);
		end
		// Quiet window for trailing strobes
		repeat (quiet_cycles) @(posedge posedge_clk);
		spw_rx_checker_inst.report_leftovers();
		errors = spw_rx_checker_inst.error_total();
		$display("Summary: %0d tokens checked, %0d mismatches, %0d unexpected, %0d missing",
			spw_rx_checker_inst.token_count, spw_rx_checker_inst.mismatch_count,
			spw_rx_checker_inst.unexpected_count, spw_rx_checker_inst.missing_count);
		if (errors == 0 && !timed_out)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* spw_rx_checker.sv */
/*
 * SpaceWire receiver output checker
 * Holds the expected token stream from the testbench model and compares
 * every output strobe of the receiver with it, in order.
 */

`timescale 1ns/100ps
`default_nettype none

module spw_rx_checker (
	input  logic posedge_clk,
	input  logic rx_resetn,
	input  logic [7:0] rx_data,
	input  logic rx_data_valid,
	input  logic rx_eop,
	input  logic rx_eep,
	input  logic rx_fct,
	input  logic rx_null,
	input  logic [5:0] rx_time,
	input  logic [1:0] rx_time_flags,
	input  logic rx_time_valid,
	input  logic parity_error,
	input  logic escape_error
);

	// Token kinds, each the index of its strobe below
	localparam int kind_data    = 0;
	localparam int kind_time    = 5;

	// Kind on top, payload byte below
	logic [10:0] expect_q[$];
	logic [7:0] strobes;
	int token_count = 0;
	int mismatch_count = 0;
	int unexpected_count = 0;
	int missing_count = 0;

	assign strobes = {escape_error, parity_error, rx_time_valid, rx_null,
		rx_fct, rx_eep, rx_eop, rx_data_valid};

	function automatic string kind_name(input int kind);
		case (kind)
			0: return "rx_data_valid";
			1: return "rx_eop";
			2: return "rx_eep";
			3: return "rx_fct";
			4: return "rx_null";
			5: return "rx_time_valid";
			6: return "parity_error";
			default: return "escape_error";
		endcase
	endfunction

	// ------------------------------------------------------------------------
	// Access from the testbench
	// ------------------------------------------------------------------------

	task automatic push_expected(input int kind, input logic [7:0] value);
		expect_q.push_back({3'(kind), value});
	endtask

	function automatic int pending_count();
		return expect_q.size();
	endfunction

	function automatic int error_total();
		return mismatch_count + unexpected_count + missing_count;
	endfunction

	// Whatever is left never showed up
	task automatic report_leftovers();
		logic [10:0] entry;
		while (expect_q.size() > 0)
		begin
			entry = expect_q.pop_front();
			$display("Missing token: %s was expected but never came",
				kind_name(int'(entry[10:8])));
			missing_count++;
		end
	endtask

	// ------------------------------------------------------------------------
	// Comparison
	// ------------------------------------------------------------------------

	task automatic check_token(input int kind);
		logic [10:0] entry;
		int exp_kind;
		logic [7:0] exp_byte;
		if (expect_q.size() == 0)
		begin
			$display("Unexpected %s strobe at time %0t with no token expected",
				kind_name(kind), $time);
			unexpected_count++;
		end
		else
		begin
			entry = expect_q.pop_front();
			exp_kind = int'(entry[10:8]);
			exp_byte = entry[7:0];
			token_count++;
			if (exp_kind != kind)
			begin
				$display("Wrong token at time %0t: %s strobe where %s was expected",
					$time, kind_name(kind), kind_name(exp_kind));
				unexpected_count++;
			end
			else if (kind == kind_data && rx_data !== exp_byte)
			begin
				$display("Mismatch rx_data: expected 0x%02h, got 0x%02h", exp_byte, rx_data);
				mismatch_count++;
			end
			else if (kind == kind_time)
			begin
				// Time value in the low six bits
				if (rx_time !== exp_byte[5:0])
				begin
					$display("Mismatch rx_time: expected 0x%02h, got 0x%02h",
						exp_byte[5:0], rx_time);
					mismatch_count++;
				end
				// Flags in the top two
				if (rx_time_flags !== exp_byte[7:6])
				begin
					$display("Mismatch rx_time_flags: expected 0x%01h, got 0x%01h",
						exp_byte[7:6], rx_time_flags);
					mismatch_count++;
				end
			end
		end
	endtask

	// Outputs settle after the rising edge, so look at the falling one
	always @(negedge posedge_clk)
	begin
		if (rx_resetn)
		begin
			if ($countones(strobes) > 1)
			begin
				$display("Several output strobes high in one cycle at time %0t: %b",
					$time, strobes);
				unexpected_count++;
			end
			for (int k = 0; k < 8; k++)
				if (strobes[k])
					check_token(k);
		end
	end

endmodule

`default_nettype wire

/* spw_rx_top.sv */
/*
 * SpaceWire receiver top
 * Bit recovery, character framing, field latch and token classifier
 * chained in the system clock domain.
 */

`timescale 1ns/100ps
`default_nettype none

module spw_rx_top (
	input  logic posedge_clk,
	input  logic rx_resetn,
	input  logic din,
	input  logic sin,
	output logic [spw_rx_pkg::spw_data_bits-1:0] rx_data,
	output logic rx_data_valid,
	output logic rx_eop,
	output logic rx_eep,
	output logic rx_fct,
	output logic rx_null,
	output logic [5:0] rx_time,
	output logic [1:0] rx_time_flags,
	output logic rx_time_valid,
	output logic parity_error,
	output logic escape_error
);

	import spw_rx_pkg::*;

	// Recovered bits
	logic bit_valid;
	logic bit_value;

	// Framed character
	logic char_done;
	logic is_control;
	logic flag_bit;
	logic parity_bit;
	logic [spw_data_bits-1:0] data_bits;
	logic [1:0] code_bits;
	logic last_is_control;
	logic last_is_data;

	// Latched fields
	logic [spw_data_bits:0] dta_timec_p;
	logic parity_rec_d;
	logic parity_rec_d_gen;
	logic [2:0] control_p_r;
	logic [2:0] control_l_r;
	logic parity_rec_c;
	logic parity_rec_c_gen;
	logic data_ready;
	logic control_ready;
	logic parity_checkable;

	spw_rx_bit_recovery spw_rx_bit_recovery_inst (
		.posedge_clk (posedge_clk),
		.rx_resetn   (rx_resetn),
		.din         (din),
		.sin         (sin),
		.bit_valid   (bit_valid),
		.bit_value   (bit_value)
	);

	spw_rx_char_shift spw_rx_char_shift_inst (
		.posedge_clk     (posedge_clk),
		.rx_resetn       (rx_resetn),
		.bit_valid       (bit_valid),
		.bit_value       (bit_value),
		.char_done       (char_done),
		.is_control      (is_control),
		.flag_bit        (flag_bit),
		.parity_bit      (parity_bit),
		.data_bits       (data_bits),
		.code_bits       (code_bits),
		.last_is_control (last_is_control),
		.last_is_data    (last_is_data)
	);

	spw_rx_char_decode spw_rx_char_decode_inst (
		.posedge_clk      (posedge_clk),
		.rx_resetn        (rx_resetn),
		.char_done        (char_done),
		.is_control       (is_control),
		.flag_bit         (flag_bit),
		.parity_bit       (parity_bit),
		.data_bits        (data_bits),
		.code_bits        (code_bits),
		.last_is_control  (last_is_control),
		.last_is_data     (last_is_data),
		.dta_timec_p      (dta_timec_p),
		.parity_rec_d     (parity_rec_d),
		.parity_rec_d_gen (parity_rec_d_gen),
		.control_p_r      (control_p_r),
		.control_l_r      (control_l_r),
		.parity_rec_c     (parity_rec_c),
		.parity_rec_c_gen (parity_rec_c_gen),
		.data_ready       (data_ready),
		.control_ready    (control_ready),
		.parity_checkable (parity_checkable)
	);

	spw_rx_classify spw_rx_classify_inst (
		.posedge_clk      (posedge_clk),
		.rx_resetn        (rx_resetn),
		.dta_timec_p      (dta_timec_p),
		.parity_rec_d     (parity_rec_d),
		.parity_rec_d_gen (parity_rec_d_gen),
		.control_p_r      (control_p_r),
		.control_l_r      (control_l_r),
		.parity_rec_c     (parity_rec_c),
		.parity_rec_c_gen (parity_rec_c_gen),
		.data_ready       (data_ready),
		.control_ready    (control_ready),
		.parity_checkable (parity_checkable),
		.rx_data          (rx_data),
		.rx_data_valid    (rx_data_valid),
		.rx_eop           (rx_eop),
		.rx_eep           (rx_eep),
		.rx_fct           (rx_fct),
		.rx_null          (rx_null),
		.rx_time          (rx_time),
		.rx_time_flags    (rx_time_flags),
		.rx_time_valid    (rx_time_valid),
		.parity_error     (parity_error),
		.escape_error     (escape_error)
	);

endmodule

`default_nettype wire

/* spw_rx_classify.sv */
/*
 * SpaceWire token classifier
 * Checks parity of each latched character, resolves ESC sequences into
 * NULL, time codes or escape errors and raises one output strobe per
 * decoded token.
 */

`timescale 1ns/100ps
`default_nettype none

module spw_rx_classify (
	input  logic posedge_clk,
	input  logic rx_resetn,
	input  logic [spw_rx_pkg::spw_data_bits:0] dta_timec_p,
	input  logic parity_rec_d,
	input  logic parity_rec_d_gen,
	input  logic [2:0] control_p_r,
	input  logic [2:0] control_l_r,
	input  logic parity_rec_c,
	input  logic parity_rec_c_gen,
	input  logic data_ready,
	input  logic control_ready,
	input  logic parity_checkable,
	output logic [spw_rx_pkg::spw_data_bits-1:0] rx_data,
	output logic rx_data_valid,
	output logic rx_eop,
	output logic rx_eep,
	output logic rx_fct,
	output logic rx_null,
	output logic [5:0] rx_time,
	output logic [1:0] rx_time_flags,
	output logic rx_time_valid,
	output logic parity_error,
	output logic escape_error
);

	import spw_rx_pkg::*;

	spw_char_u byte_u;
	logic data_par_ok;
	logic ctrl_par_ok;
	// Previous token was a lone ESC
	logic esc_pending;
	logic esc_before_ctrl;
	logic [1:0] ctrl_code;

	assign byte_u      = dta_timec_p[spw_data_bits-1:0];
	assign ctrl_code   = control_p_r[1:0];
	assign data_par_ok = !parity_checkable || (parity_rec_d == parity_rec_d_gen);
	assign ctrl_par_ok = !parity_checkable || (parity_rec_c == parity_rec_c_gen);
	// History from decode agrees with the pending flag
	assign esc_before_ctrl = esc_pending && (control_l_r[1:0] == spw_code_esc);

	// ------------------------------------------------------------------------
	// Token strobes
	// ------------------------------------------------------------------------

	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			rx_data_valid <= 1'b0;
			rx_eop        <= 1'b0;
			rx_eep        <= 1'b0;
			rx_fct        <= 1'b0;
			rx_null       <= 1'b0;
			rx_time_valid <= 1'b0;
			parity_error  <= 1'b0;
			escape_error  <= 1'b0;
			esc_pending   <= 1'b0;
		end
		else
		begin
			rx_data_valid <= 1'b0;
			rx_eop        <= 1'b0;
			rx_eep        <= 1'b0;
			rx_fct        <= 1'b0;
			rx_null       <= 1'b0;
			rx_time_valid <= 1'b0;
			parity_error  <= 1'b0;
			escape_error  <= 1'b0;
			if (data_ready)
			begin
				esc_pending <= 1'b0;
				if (!data_par_ok)
					parity_error <= 1'b1;
				else if (esc_pending)
					rx_time_valid <= 1'b1;
				else
					rx_data_valid <= 1'b1;
			end
			else if (control_ready)
			begin
				if (!ctrl_par_ok)
				begin
					parity_error <= 1'b1;
					esc_pending  <= 1'b0;
				end
				else if (esc_before_ctrl)
				begin
					// Only ESC FCT is legal, as NULL
					esc_pending <= 1'b0;
					if (ctrl_code == spw_code_fct)
						rx_null <= 1'b1;
					else
						escape_error <= 1'b1;
				end
				else
				begin
					case (ctrl_code)
						spw_code_fct: rx_fct <= 1'b1;
						spw_code_eop: rx_eop <= 1'b1;
						spw_code_eep: rx_eep <= 1'b1;
						// Lone ESC waits for its partner
						default:      esc_pending <= 1'b1;
					endcase
				end
			end
		end
	end

	// Same byte read both ways
	always_ff @(posedge posedge_clk)
	begin
		if (data_ready)
		begin
			rx_data       <= byte_u.data;
			rx_time       <= byte_u.tc.value;
			rx_time_flags <= byte_u.tc.flags;
		end
	end

	a_one_strobe: assert property (
		@(posedge posedge_clk) disable iff (!rx_resetn)
		$onehot0({rx_data_valid, rx_eop, rx_eep, rx_fct, rx_null,
			rx_time_valid, parity_error, escape_error})
	);

endmodule

`default_nettype wire

/* spw_rx_char_decode.sv */
/*
 * SpaceWire character field latch
 * Holds the latest data and control character fields until the next
 * character, keeps one step of control history and computes the parity
 * expected from the flag and the previous character's bits.
 */

`timescale 1ns/100ps
`default_nettype none

module spw_rx_char_decode (
	input  logic posedge_clk,
	input  logic rx_resetn,
	input  logic char_done,
	input  logic is_control,
	input  logic flag_bit,
	input  logic parity_bit,
	input  logic [spw_rx_pkg::spw_data_bits-1:0] data_bits,
	input  logic [1:0] code_bits,
	input  logic last_is_control,
	input  logic last_is_data,
	output logic [spw_rx_pkg::spw_data_bits:0] dta_timec_p,
	output logic parity_rec_d,
	output logic parity_rec_d_gen,
	output logic [2:0] control_p_r,
	output logic [2:0] control_l_r,
	output logic parity_rec_c,
	output logic parity_rec_c_gen,
	output logic data_ready,
	output logic control_ready,
	output logic parity_checkable
);

	import spw_rx_pkg::*;

	// XOR of the bits covered from the previous char
	logic prev_par;

	always_comb
	begin
		if (last_is_control)
			prev_par = ^control_p_r[1:0];
		else if (last_is_data)
			prev_par = ^dta_timec_p[spw_data_bits-1:0];
		else
			prev_par = 1'b0;
	end

	// ------------------------------------------------------------------------
	// Ready strobes and control history
	// ------------------------------------------------------------------------

	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			control_p_r      <= 3'd0;
			control_l_r      <= 3'd0;
			data_ready       <= 1'b0;
			control_ready    <= 1'b0;
			parity_checkable <= 1'b0;
		end
		else
		begin
			data_ready    <= char_done & ~is_control;
			control_ready <= char_done & is_control;
			if (char_done)
			begin
				// Nothing to check against on the very first char
				parity_checkable <= last_is_control | last_is_data;
				if (!is_control)
				begin
					// Data breaks any control sequence
					control_p_r <= 3'd0;
					control_l_r <= 3'd0;
				end
				else
				begin
					control_p_r <= {flag_bit, code_bits};
					control_l_r <= control_p_r;
				end
			end
		end
	end

	// ------------------------------------------------------------------------
	// Field latch and expected parity
	// ------------------------------------------------------------------------

	always_ff @(posedge posedge_clk)
	begin
		if (char_done)
		begin
			if (!is_control)
			begin
				dta_timec_p      <= {flag_bit, data_bits};
				parity_rec_d     <= parity_bit;
				// Odd parity over flag and previous payload
				parity_rec_d_gen <= ~(flag_bit ^ prev_par);
			end
			else
			begin
				parity_rec_c     <= parity_bit;
				parity_rec_c_gen <= ~(flag_bit ^ prev_par);
			end
		end
	end

	// One char per char_done so one kind per cycle
	a_one_ready: assert property (
		@(posedge posedge_clk) disable iff (!rx_resetn)
		!(data_ready && control_ready)
	);

endmodule

`default_nettype wire

/* spw_rx_char_shift.sv */
/*
 * SpaceWire character framing
 * Collects recovered bits, takes parity and flag from the first two,
 * then shifts in two code bits or eight data bits, LSB first.
 * Also reports the kind of the character before the current one.
 */

`timescale 1ns/100ps
`default_nettype none

module spw_rx_char_shift (
	input  logic posedge_clk,
	input  logic rx_resetn,
	input  logic bit_valid,
	input  logic bit_value,
	output logic char_done,
	output logic is_control,
	output logic flag_bit,
	output logic parity_bit,
	output logic [spw_rx_pkg::spw_data_bits-1:0] data_bits,
	output logic [1:0] code_bits,
	output logic last_is_control,
	output logic last_is_data
);

	import spw_rx_pkg::*;

	// Bits taken so far in this character
	logic [3:0] bit_cnt;
	// Flag of the character in progress
	logic flag_q;
	logic par_q;
	// Payload shifter, newest bit on top
	logic [spw_data_bits-1:0] pay_q;
	// At least one character already framed
	logic have_char;
	// Index of the final bit
	logic [3:0] last_idx;
	logic last_bit;

	// Control characters end early
	assign last_idx = flag_q ? 4'(spw_ctrl_char_bits - 1) : 4'(spw_data_char_bits - 1);
	// Flag is settled by bit 2 so no false end before that
	assign last_bit = bit_valid && (bit_cnt == last_idx);

	// ------------------------------------------------------------------------
	// Framing control
	// ------------------------------------------------------------------------

	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			bit_cnt         <= 4'd0;
			flag_q          <= 1'b0;
			char_done       <= 1'b0;
			is_control      <= 1'b0;
			have_char       <= 1'b0;
			last_is_control <= 1'b0;
			last_is_data    <= 1'b0;
		end
		else
		begin
			char_done <= 1'b0;
			if (bit_valid)
			begin
				// Second bit is the flag
				if (bit_cnt == 4'd1)
					flag_q <= bit_value;
				if (last_bit)
				begin
					bit_cnt    <= 4'd0;
					char_done  <= 1'b1;
					is_control <= flag_q;
					// is_control still holds the previous kind here
					last_is_control <= have_char & is_control;
					last_is_data    <= have_char & ~is_control;
					have_char       <= 1'b1;
				end
				else
					bit_cnt <= bit_cnt + 4'd1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Field capture
	// ------------------------------------------------------------------------

	always_ff @(posedge posedge_clk)
	begin
		if (bit_valid)
		begin
			// First bit is parity
			if (bit_cnt == 4'd0)
				par_q <= bit_value;
			if (bit_cnt >= 4'd2)
				pay_q <= {bit_value, pay_q[spw_data_bits-1:1]};
			if (last_bit)
			begin
				parity_bit <= par_q;
				flag_bit   <= flag_q;
				data_bits  <= {bit_value, pay_q[spw_data_bits-1:1]};
				// Only two payload bits for a control char
				code_bits  <= {bit_value, pay_q[spw_data_bits-1]};
			end
		end
	end

	// Counter wraps at the end of the longest char
	a_cnt_range: assert property (
		@(posedge posedge_clk) disable iff (!rx_resetn)
		bit_cnt <= 4'(spw_data_char_bits)
	);

endmodule

`default_nettype wire

/* spw_rx_bit_recovery.sv */
/*
 * SpaceWire data-strobe bit recovery
 * Brings the data and strobe lines into the system clock domain and
 * emits one bit strobe for every change of their XOR, together with
 * the synchronized data line as the bit value.
 */

`timescale 1ns/100ps
`default_nettype none

module spw_rx_bit_recovery (
	input  logic posedge_clk,
	input  logic rx_resetn,
	input  logic din,
	input  logic sin,
	output logic bit_valid,
	output logic bit_value
);

	// ------------------------------------------------------------------------
	// Two-flop synchronizers
	// ------------------------------------------------------------------------

	logic d_meta;
	logic d_sync;
	logic s_meta;
	logic s_sync;
	// Last seen XOR of the lines
	logic ds_xor_q;

	always_ff @(posedge posedge_clk or negedge rx_resetn)
	begin
		if (!rx_resetn)
		begin
			d_meta    <= 1'b0;
			d_sync    <= 1'b0;
			s_meta    <= 1'b0;
			s_sync    <= 1'b0;
			ds_xor_q  <= 1'b0;
			bit_valid <= 1'b0;
		end
		else
		begin
			d_meta <= din;
			d_sync <= d_meta;
			s_meta <= sin;
			s_sync <= s_meta;
			// Any change of D xor S marks a new bit
			ds_xor_q  <= d_sync ^ s_sync;
			bit_valid <= (d_sync ^ s_sync) ^ ds_xor_q;
		end
	end

	// Bit value travels with the strobe
	always_ff @(posedge posedge_clk)
	begin
		bit_value <= d_sync;
	end

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------

	// DS encoding moves only one line per bit
	a_one_line_moves: assert property (
		@(posedge posedge_clk) disable iff (!rx_resetn)
		!($changed(d_sync) && $changed(s_sync))
	);

endmodule

`default_nettype wire

/* spw_rx_pkg.sv */
/*
 * SpaceWire receiver shared definitions
 * Character widths, control codes and the received payload byte,
 * which is read either as a data byte or as a time code.
 */

`default_nettype none

package spw_rx_pkg;

	// ------------------------------------------------------------------------
	// Character widths
	// ------------------------------------------------------------------------

	// Payload of a data character
	localparam int spw_data_bits = 8;
	// Parity, flag and eight data bits
	localparam int spw_data_char_bits = 10;
	// Parity, flag and two code bits
	localparam int spw_ctrl_char_bits = 4;

	// ------------------------------------------------------------------------
	// Control codes
	// ------------------------------------------------------------------------

	localparam logic [1:0] spw_code_fct = 2'd0;
	localparam logic [1:0] spw_code_eop = 2'd1;
	localparam logic [1:0] spw_code_eep = 2'd2;
	localparam logic [1:0] spw_code_esc = 2'd3;

	// ------------------------------------------------------------------------
	// Received payload byte
	// ------------------------------------------------------------------------

	// Plain data view, or time code view when ESC came first
	typedef union packed {
		logic [spw_data_bits-1:0] data;
		struct packed {
			// Two control flags on top
			logic [1:0] flags;
			// Six bit time counter
			logic [5:0] value;
		} tc;
	} spw_char_u;

endpackage

`default_nettype wire
